// File: noc_consts.svh
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mesh geometry and message field widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define NOC_COORD_WIDTH 2     // all ones (3) lies outside the grid and marks broadcast

`define NOC_PAYLOAD_WIDTH 16

`define NOC_FIFO_DEPTH 4      // entries per router input port

`define NOC_MESH_ROWS 2

`define NOC_MESH_COLS 2

`endif

// File: noc_msg_pkg.sv
`include "noc_consts.svh"

package noc_msg_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // message kind, carried end to end but never looked at by the routers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [1:0] {
    MSG_DATA = 2'd0,
    MSG_REQ  = 2'd1,
    MSG_RESP = 2'd2,
    MSG_CTRL = 2'd3
  } msg_kind_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // packed message, destination in the top bits
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [`NOC_COORD_WIDTH-1:0]   dest_row;   // all ones in both dest fields means broadcast
    logic [`NOC_COORD_WIDTH-1:0]   dest_col;
    logic [`NOC_COORD_WIDTH-1:0]   src_row;
    logic [`NOC_COORD_WIDTH-1:0]   src_col;
    msg_kind_t                     kind;
    logic [`NOC_PAYLOAD_WIDTH-1:0] payload;
  } noc_msg_t;

endpackage

// File: noc_route_pkg.sv
`include "noc_consts.svh"

package noc_route_pkg;

  typedef logic [`NOC_COORD_WIDTH-1:0] coord_t;

  // enum order is also the fixed selection priority
  typedef enum logic [2:0] {
    DIR_SELF  = 3'd0,
    DIR_NORTH = 3'd1,   // row minus one
    DIR_SOUTH = 3'd2,
    DIR_EAST  = 3'd3,
    DIR_WEST  = 3'd4    // column minus one
  } port_dir_t;

  // one-hop broadcast is flagged by all ones in both coordinates
  function automatic logic is_bcast(input coord_t row, input coord_t col);
    return (&row) && (&col);
  endfunction

endpackage

// File: msg_fifo.sv
`timescale 1ns/1ps
`include "noc_consts.svh"

module msg_fifo #(
  parameter int DEPTH = `NOC_FIFO_DEPTH
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  noc_msg_pkg::noc_msg_t wr_data,
  input  logic                  wr_en,
  input  logic                  pop,
  output noc_msg_pkg::noc_msg_t rd_data,
  output logic                  full,
  output logic                  empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  noc_msg_pkg::noc_msg_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // wrap by compare so DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign rd_data = mem[rd_ptr];              // head is always visible
  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({wr_en, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // both or neither leave occupancy unchanged
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // the router owns the handshakes, so these guard its side of the contract
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n) pop |-> !empty
  );

  a_no_write_full: assert property (
    @(posedge clk) disable iff (!rst_n) wr_en |-> !full
  );

endmodule

// File: noc_router.sv
`timescale 1ns/1ps
`include "noc_consts.svh"

module noc_router (
  input  logic                  clk,
  input  logic                  rst_n,
  input  noc_route_pkg::coord_t row_id,
  input  noc_route_pkg::coord_t col_id,

  input  noc_msg_pkg::noc_msg_t in_self_value,
  input  logic                  in_self_valid,
  output logic                  in_self_ready,
  input  noc_msg_pkg::noc_msg_t in_north_value,
  input  logic                  in_north_valid,
  output logic                  in_north_ready,
  input  noc_msg_pkg::noc_msg_t in_south_value,
  input  logic                  in_south_valid,
  output logic                  in_south_ready,
  input  noc_msg_pkg::noc_msg_t in_east_value,
  input  logic                  in_east_valid,
  output logic                  in_east_ready,
  input  noc_msg_pkg::noc_msg_t in_west_value,
  input  logic                  in_west_valid,
  output logic                  in_west_ready,

  output noc_msg_pkg::noc_msg_t out_self_value,
  output logic                  out_self_valid,
  input  logic                  out_self_ready,
  output noc_msg_pkg::noc_msg_t out_north_value,
  output logic                  out_north_valid,
  input  logic                  out_north_ready,
  output noc_msg_pkg::noc_msg_t out_south_value,
  output logic                  out_south_valid,
  input  logic                  out_south_ready,
  output noc_msg_pkg::noc_msg_t out_east_value,
  output logic                  out_east_valid,
  input  logic                  out_east_ready,
  output noc_msg_pkg::noc_msg_t out_west_value,
  output logic                  out_west_valid,
  input  logic                  out_west_ready
);

  localparam int NUM_PORTS = 5;

  noc_msg_pkg::noc_msg_t in_value   [NUM_PORTS];
  noc_msg_pkg::noc_msg_t head_value [NUM_PORTS];

  logic [NUM_PORTS-1:0] in_valid;
  logic [NUM_PORTS-1:0] wr_en;
  logic [NUM_PORTS-1:0] pop;
  logic [NUM_PORTS-1:0] full;
  logic [NUM_PORTS-1:0] empty;
  logic [NUM_PORTS-1:0] out_ready;
  logic [NUM_PORTS-1:0] out_valid;

  noc_route_pkg::port_dir_t sel_dir;
  noc_route_pkg::port_dir_t route_dir;
  noc_msg_pkg::noc_msg_t    head;

  logic sel_valid;
  logic bcast;
  logic nbr_ready;
  logic fire;

  // copy of a message with a new destination, everything else kept
  function automatic noc_msg_pkg::noc_msg_t retarget(
    input noc_msg_pkg::noc_msg_t msg,
    input noc_route_pkg::coord_t row,
    input noc_route_pkg::coord_t col
  );
    noc_msg_pkg::noc_msg_t copy;
    copy          = msg;
    copy.dest_row = row;
    copy.dest_col = col;
    return copy;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // input buffering, vectors are indexed by port_dir_t
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign in_value = '{in_self_value, in_north_value, in_south_value,
                      in_east_value, in_west_value};
  assign in_valid = {in_west_valid, in_east_valid, in_south_valid,
                     in_north_valid, in_self_valid};

  assign {in_west_ready, in_east_ready, in_south_ready,
          in_north_ready, in_self_ready} = ~full;       // ready never looks at valid

  assign wr_en = in_valid & ~full;

  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_fifo
    msg_fifo #(
      .DEPTH (`NOC_FIFO_DEPTH)
    ) u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_data (in_value[i]),
      .wr_en   (wr_en[i]),
      .pop     (pop[i]),
      .rd_data (head_value[i]),
      .full    (full[i]),
      .empty   (empty[i])
    );
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // fixed-priority pick and XY routing
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    sel_valid = 1'b0;
    sel_dir   = noc_route_pkg::DIR_SELF;
    for (int i = NUM_PORTS - 1; i >= 0; i--) begin   // lowest index wins, so scan downwards
      if (!empty[i]) begin
        sel_valid = 1'b1;
        sel_dir   = noc_route_pkg::port_dir_t'(i);
      end
    end
  end

  assign head = head_value[sel_dir];

  assign bcast     = noc_route_pkg::is_bcast(head.dest_row, head.dest_col);
  assign nbr_ready = out_north_ready & out_south_ready & out_east_ready & out_west_ready;

  always_comb begin
    if (head.dest_row == row_id && head.dest_col == col_id) begin
      route_dir = noc_route_pkg::DIR_SELF;
    end else if (head.dest_row < row_id) begin
      route_dir = noc_route_pkg::DIR_NORTH;          // row is corrected first
    end else if (head.dest_row > row_id) begin
      route_dir = noc_route_pkg::DIR_SOUTH;
    end else if (head.dest_col > col_id) begin
      route_dir = noc_route_pkg::DIR_EAST;
    end else begin
      route_dir = noc_route_pkg::DIR_WEST;
    end
  end

  assign out_ready = {out_west_ready, out_east_ready, out_south_ready,
                      out_north_ready, out_self_ready};

  always_comb begin
    out_valid = '0;
    fire      = 1'b0;
    if (sel_valid) begin
      if (bcast) begin
        if (nbr_ready) begin                           // all four copies leave together
          out_valid[noc_route_pkg::DIR_NORTH] = 1'b1;
          out_valid[noc_route_pkg::DIR_SOUTH] = 1'b1;
          out_valid[noc_route_pkg::DIR_EAST]  = 1'b1;
          out_valid[noc_route_pkg::DIR_WEST]  = 1'b1;
        end
        fire = nbr_ready;
      end else begin
        out_valid[route_dir] = 1'b1;
        fire                 = out_ready[route_dir];
      end
    end
  end

  always_comb begin
    pop = '0;
    if (fire) begin
      pop[sel_dir] = 1'b1;                             // head pops on the transfer edge
    end
  end

  assign {out_west_valid, out_east_valid, out_south_valid,
          out_north_valid, out_self_valid} = out_valid;

  // broadcast copies carry the neighbour's own coordinates
  assign out_self_value  = head;
  assign out_north_value = bcast ?
    retarget(head, noc_route_pkg::coord_t'(row_id - 1'b1), col_id) : head;
  assign out_south_value = bcast ?
    retarget(head, noc_route_pkg::coord_t'(row_id + 1'b1), col_id) : head;
  assign out_east_value  = bcast ?
    retarget(head, row_id, noc_route_pkg::coord_t'(col_id + 1'b1)) : head;
  assign out_west_value  = bcast ?
    retarget(head, row_id, noc_route_pkg::coord_t'(col_id - 1'b1)) : head;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_single_pop: assert property (
    @(posedge clk) disable iff (!rst_n) $onehot0(pop)
  );

  a_pop_selected: assert property (
    @(posedge clk) disable iff (!rst_n) (|pop) |-> ((pop & empty) == '0)
  );

  a_self_exclusive: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_self_valid |-> !(out_north_valid || out_south_valid ||
                         out_east_valid || out_west_valid)
  );

endmodule

// File: noc_mesh.sv
`timescale 1ns/1ps
`include "noc_consts.svh"

module noc_mesh (
  input  logic                  clk,
  input  logic                  rst_n,
  input  noc_msg_pkg::noc_msg_t inject_value [`NOC_MESH_ROWS*`NOC_MESH_COLS],
  input  logic                  inject_valid [`NOC_MESH_ROWS*`NOC_MESH_COLS],
  output logic                  inject_ready [`NOC_MESH_ROWS*`NOC_MESH_COLS],
  output noc_msg_pkg::noc_msg_t eject_value  [`NOC_MESH_ROWS*`NOC_MESH_COLS],
  output logic                  eject_valid  [`NOC_MESH_ROWS*`NOC_MESH_COLS],
  input  logic                  eject_ready  [`NOC_MESH_ROWS*`NOC_MESH_COLS]
);

  localparam int ROWS  = `NOC_MESH_ROWS;
  localparam int COLS  = `NOC_MESH_COLS;
  localparam int NODES = ROWS * COLS;

  // router outputs per node, plus the ready each output sees
  noc_msg_pkg::noc_msg_t out_n_value [NODES];
  noc_msg_pkg::noc_msg_t out_s_value [NODES];
  noc_msg_pkg::noc_msg_t out_e_value [NODES];
  noc_msg_pkg::noc_msg_t out_w_value [NODES];
  logic                  out_n_valid [NODES];
  logic                  out_s_valid [NODES];
  logic                  out_e_valid [NODES];
  logic                  out_w_valid [NODES];
  logic                  out_n_ready [NODES];
  logic                  out_s_ready [NODES];
  logic                  out_e_ready [NODES];
  logic                  out_w_ready [NODES];

  // ready given back by each router input
  logic                  in_n_ready  [NODES];
  logic                  in_s_ready  [NODES];
  logic                  in_e_ready  [NODES];
  logic                  in_w_ready  [NODES];

  for (genvar r = 0; r < ROWS; r++) begin : g_row
    for (genvar c = 0; c < COLS; c++) begin : g_col
      localparam int IDX = r * COLS + c;

      noc_msg_pkg::noc_msg_t lnk_n_value;
      noc_msg_pkg::noc_msg_t lnk_s_value;
      noc_msg_pkg::noc_msg_t lnk_e_value;
      noc_msg_pkg::noc_msg_t lnk_w_value;
      logic                  lnk_n_valid;
      logic                  lnk_s_valid;
      logic                  lnk_e_valid;
      logic                  lnk_w_valid;

      // off-mesh outputs always accept and their copies vanish
      if (r > 0) begin : g_n
        assign lnk_n_value      = out_s_value[IDX-COLS];
        assign lnk_n_valid      = out_s_valid[IDX-COLS];
        assign out_n_ready[IDX] = in_s_ready[IDX-COLS];
      end else begin : g_n_edge
        assign lnk_n_value      = '0;
        assign lnk_n_valid      = 1'b0;
        assign out_n_ready[IDX] = 1'b1;
      end

      if (r < ROWS - 1) begin : g_s
        assign lnk_s_value      = out_n_value[IDX+COLS];
        assign lnk_s_valid      = out_n_valid[IDX+COLS];
        assign out_s_ready[IDX] = in_n_ready[IDX+COLS];
      end else begin : g_s_edge
        assign lnk_s_value      = '0;
        assign lnk_s_valid      = 1'b0;
        assign out_s_ready[IDX] = 1'b1;
      end

      if (c < COLS - 1) begin : g_e
        assign lnk_e_value      = out_w_value[IDX+1];
        assign lnk_e_valid      = out_w_valid[IDX+1];
        assign out_e_ready[IDX] = in_w_ready[IDX+1];
      end else begin : g_e_edge
        assign lnk_e_value      = '0;
        assign lnk_e_valid      = 1'b0;
        assign out_e_ready[IDX] = 1'b1;
      end

      if (c > 0) begin : g_w
        assign lnk_w_value      = out_e_value[IDX-1];
        assign lnk_w_valid      = out_e_valid[IDX-1];
        assign out_w_ready[IDX] = in_e_ready[IDX-1];
      end else begin : g_w_edge
        assign lnk_w_value      = '0;
        assign lnk_w_valid      = 1'b0;
        assign out_w_ready[IDX] = 1'b1;
      end

      noc_router u_router (
        .clk             (clk),
        .rst_n           (rst_n),
        .row_id          (noc_route_pkg::coord_t'(r)),
        .col_id          (noc_route_pkg::coord_t'(c)),
        .in_self_value   (inject_value[IDX]),
        .in_self_valid   (inject_valid[IDX]),
        .in_self_ready   (inject_ready[IDX]),
        .in_north_value  (lnk_n_value),
        .in_north_valid  (lnk_n_valid),
        .in_north_ready  (in_n_ready[IDX]),
        .in_south_value  (lnk_s_value),
        .in_south_valid  (lnk_s_valid),
        .in_south_ready  (in_s_ready[IDX]),
        .in_east_value   (lnk_e_value),
        .in_east_valid   (lnk_e_valid),
        .in_east_ready   (in_e_ready[IDX]),
        .in_west_value   (lnk_w_value),
        .in_west_valid   (lnk_w_valid),
        .in_west_ready   (in_w_ready[IDX]),
        .out_self_value  (eject_value[IDX]),
        .out_self_valid  (eject_valid[IDX]),
        .out_self_ready  (eject_ready[IDX]),
        .out_north_value (out_n_value[IDX]),
        .out_north_valid (out_n_valid[IDX]),
        .out_north_ready (out_n_ready[IDX]),
        .out_south_value (out_s_value[IDX]),
        .out_south_valid (out_s_valid[IDX]),
        .out_south_ready (out_s_ready[IDX]),
        .out_east_value  (out_e_value[IDX]),
        .out_east_valid  (out_e_valid[IDX]),
        .out_east_ready  (out_e_ready[IDX]),
        .out_west_value  (out_w_value[IDX]),
        .out_west_valid  (out_w_valid[IDX]),
        .out_west_ready  (out_w_ready[IDX])
      );
    end
  end

endmodule

// File: tb_noc_mesh.sv
`timescale 1ns/1ps
`include "noc_consts.svh"

module tb_noc_mesh;

  localparam int ROWS           = `NOC_MESH_ROWS;
  localparam int COLS           = `NOC_MESH_COLS;
  localparam int NODES          = ROWS * COLS;
  localparam int COORD_W        = `NOC_COORD_WIDTH;
  localparam int BCAST          = (1 << COORD_W) - 1;
  localparam int MAX_INFLIGHT   = 6;     // heads can only block each other once two FIFOs are full
  localparam int RANDOM_MSGS    = 200;
  localparam int TIMEOUT_CYCLES = 4000;  // about 230 messages at up to 16 cycles each, with margin

  logic                  clk;
  logic                  rst_n;
  noc_msg_pkg::noc_msg_t inject_value [NODES];
  logic                  inject_valid [NODES];
  logic                  inject_ready [NODES];
  noc_msg_pkg::noc_msg_t eject_value  [NODES];
  logic                  eject_valid  [NODES];
  logic                  eject_ready  [NODES] = '{default: 1'b1};

  noc_msg_pkg::noc_msg_t exp_q [NODES][$];  // expected deliveries, one queue per ejecting node

  int   seed = 27426;
  int   ready_seed;
  int   cycle_count;
  int   errors;
  int   errors_at_start;
  int   tests_passed;
  int   tests_failed;
  logic stall_node3;
  logic random_ready;

  noc_mesh u_noc_mesh (
    .clk          (clk),
    .rst_n        (rst_n),
    .inject_value (inject_value),
    .inject_valid (inject_valid),
    .inject_ready (inject_ready),
    .eject_value  (eject_value),
    .eject_valid  (eject_valid),
    .eject_ready  (eject_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout: run hit %0d cycles with deliveries still outstanding", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model and scoreboard
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic noc_msg_pkg::noc_msg_t make_msg(
    input int src,
    input int drow,
    input int dcol,
    input noc_msg_pkg::msg_kind_t kind,
    input logic [`NOC_PAYLOAD_WIDTH-1:0] payload
  );
    noc_msg_pkg::noc_msg_t m;
    m.dest_row = COORD_W'(drow);
    m.dest_col = COORD_W'(dcol);
    m.src_row  = COORD_W'(src / COLS);
    m.src_col  = COORD_W'(src % COLS);
    m.kind     = kind;
    m.payload  = payload;
    return m;
  endfunction

  // broadcast reaches the in-grid neighbours, each copy addressed to that neighbour
  function automatic void expected_targets(input noc_msg_pkg::noc_msg_t msg, input int src);
    int r;
    int c;
    int nr;
    int nc;
    noc_msg_pkg::noc_msg_t copy;
    r = src / COLS;
    c = src % COLS;
    if (msg.dest_row == BCAST && msg.dest_col == BCAST) begin
      for (int d = 1; d < 5; d++) begin
        nr = r;
        nc = c;
        case (noc_route_pkg::port_dir_t'(d))
          noc_route_pkg::DIR_NORTH: nr = r - 1;
          noc_route_pkg::DIR_SOUTH: nr = r + 1;
          noc_route_pkg::DIR_EAST:  nc = c + 1;
          default:                  nc = c - 1;
        endcase
        if (nr >= 0 && nr < ROWS && nc >= 0 && nc < COLS) begin
          copy          = msg;
          copy.dest_row = COORD_W'(nr);
          copy.dest_col = COORD_W'(nc);
          exp_q[nr * COLS + nc].push_back(copy);
        end
      end
    end else begin
      exp_q[msg.dest_row * COLS + msg.dest_col].push_back(msg);
    end
  endfunction

  function automatic int pending_count();
    int total;
    total = 0;
    for (int n = 0; n < NODES; n++) begin
      total += exp_q[n].size();
    end
    return total;
  endfunction

  // order only holds per source, so match the oldest entry from the same source
  task automatic check_eject(input int node, input noc_msg_pkg::noc_msg_t got);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_q[node].size() && idx < 0; i++) begin
      if (exp_q[node][i].src_row == got.src_row && exp_q[node][i].src_col == got.src_col) begin
        idx = i;
      end
    end
    assert (idx >= 0) else begin
      $display("node %0d ejected a message from (%0d,%0d) that was never expected there",
               node, got.src_row, got.src_col);
      errors++;
    end
    if (idx >= 0) begin
      assert (exp_q[node][idx] == got) else begin
        $display("Mismatch at %0t: node %0d ejected %h, expected %h",
                 $time, node, got, exp_q[node][idx]);
        errors++;
      end
      exp_q[node].delete(idx);
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) begin
      for (int n = 0; n < NODES; n++) begin
        if (eject_valid[n] && eject_ready[n]) begin
          check_eject(n, eject_value[n]);
        end
      end
    end
  end

  always @(posedge clk) begin
    for (int n = 0; n < NODES; n++) begin
      if (random_ready) begin
        eject_ready[n] <= ($random(ready_seed) & 3) != 0;  // ready three cycles in four
      end else begin
        eject_ready[n] <= !(stall_node3 && n == 3);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic send_msg(input int src, input noc_msg_pkg::noc_msg_t msg);
    inject_value[src] <= msg;
    inject_valid[src] <= 1'b1;
    do begin
      @(posedge clk);
    end while (!inject_ready[src]);
    inject_valid[src] <= 1'b0;
    expected_targets(msg, src);
  endtask

  task automatic wait_drain(input int limit, input string what);
    int waited;
    waited = 0;
    while (pending_count() != 0 && waited < limit) begin
      @(posedge clk);
      waited++;
    end
    repeat (4) @(posedge clk);  // catch stray late deliveries
    assert (pending_count() == 0) else begin
      $display("%s: %0d expected deliveries never arrived", what, pending_count());
      errors++;
    end
    for (int n = 0; n < NODES; n++) begin
      exp_q[n].delete();
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s finished: ok", name);
    end else begin
      tests_failed++;
      $display("test %s finished: %0d errors", name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  initial begin
    int src;
    int drow;
    int dcol;
    int waited;
    noc_msg_pkg::msg_kind_t kind;
    rst_n           = 1'b0;
    stall_node3     = 1'b0;
    random_ready    = 1'b0;
    ready_seed      = seed + 1;
    errors          = 0;
    errors_at_start = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    for (int n = 0; n < NODES; n++) begin
      inject_value[n] = '0;
      inject_valid[n] = 1'b0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    for (int n = 0; n < NODES; n++) begin
      assert (!eject_valid[n] && inject_ready[n]) else begin
        $display("node %0d is not idle after reset", n);
        errors++;
      end
    end
    finish_test("reset");

    for (int s = 0; s < NODES; s++) begin
      for (int d = 0; d < NODES; d++) begin
        send_msg(s, make_msg(s, d / COLS, d % COLS, noc_msg_pkg::MSG_DATA,
                             16'(16'hA000 + s * 16 + d)));
      end
    end
    wait_drain(200, "unicast");
    finish_test("unicast");

    for (int s = 0; s < NODES; s++) begin
      send_msg(s, make_msg(s, BCAST, BCAST, noc_msg_pkg::MSG_CTRL, 16'(16'hB000 + s)));
    end
    wait_drain(200, "broadcast");
    finish_test("broadcast");

    // node 3 stalls, so the path 0 -> 2 -> 3 fills three FIFOs of four
    stall_node3 <= 1'b1;
    repeat (2) @(posedge clk);
    for (int i = 0; i < 12; i++) begin
      send_msg(0, make_msg(0, 1, 1, noc_msg_pkg::MSG_REQ, 16'(16'hC000 + i)));
    end
    waited = 0;
    while (inject_ready[0] && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    assert (!inject_ready[0]) else begin
      $display("node 0 inject_ready stayed high while node 3 was stalled");
      errors++;
    end
    assert (eject_valid[3]) else begin
      $display("node 3 had no message waiting while its eject_ready was low");
      errors++;
    end
    stall_node3 <= 1'b0;
    wait_drain(200, "backpressure");
    finish_test("backpressure");

    random_ready <= 1'b1;
    for (int i = 0; i < RANDOM_MSGS; i++) begin
      while (pending_count() >= MAX_INFLIGHT) begin
        @(posedge clk);
      end
      src = $unsigned($random(seed)) % NODES;
      if ($unsigned($random(seed)) % 5 == 0) begin
        drow = BCAST;
        dcol = BCAST;
      end else begin
        drow = $unsigned($random(seed)) % ROWS;
        dcol = $unsigned($random(seed)) % COLS;
      end
      kind = noc_msg_pkg::msg_kind_t'($unsigned($random(seed)) % 4);
      send_msg(src, make_msg(src, drow, dcol, kind, 16'($random(seed))));
    end
    random_ready <= 1'b0;
    wait_drain(400, "random");
    finish_test("random");

    $display("tests passed %0d, tests failed %0d, errors %0d", tests_passed, tests_failed, errors);
    if (tests_failed == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: noc_mesh.f
+incdir+.
noc_msg_pkg.sv
noc_route_pkg.sv
msg_fifo.sv
noc_router.sv
noc_mesh.sv
tb_noc_mesh.sv
